/* rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Byte address width of pc and APB paddr
`define RV_ADDR_WIDTH 32

`define RV_DATA_WIDTH 32

// On-chip memory size in 32-bit words
`define RV_MEM_WORDS 1024

`define RV_UPC_WIDTH 7  // Micro-pc width

`endif

/* rv_pkg.sv */
`include "rv_settings.svh"

package rv_pkg;

	typedef enum logic [3:0] {
		grp_store,
		grp_load,
		grp_system,    // Also zero word and unknown opcodes
		grp_alu,
		grp_jalr,
		grp_branch,
		grp_upper,     // LUI and AUIPC
		grp_jal
	} op_group_e;

	// Encoded as {extra bit, funct3}
	typedef enum logic [3:0] {
		alu_add  = 4'b0000,
		alu_sll  = 4'b0001,
		alu_slt  = 4'b0010,
		alu_sltu = 4'b0011,
		alu_xor  = 4'b0100,
		alu_srl  = 4'b0101,
		alu_or   = 4'b0110,
		alu_and  = 4'b0111,
		alu_sub  = 4'b1000,
		alu_sra  = 4'b1101
	} alu_op_e;

	typedef struct packed {
		logic [`RV_UPC_WIDTH-1:0] next_upc;
		logic psel;
		logic penable;
		logic pwrite;
		logic load_insr;     // Decode and dispatch
		logic mem_access;    // Data transfer rather than fetch
		logic branch;
		logic load_pc;       // JALR link and jump
		logic store_alu;
		logic halt;
	} microop_t;

	localparam logic [`RV_UPC_WIDTH-1:0] upc_fetch  = 7'd3;
	localparam logic [`RV_UPC_WIDTH-1:0] upc_store  = 7'd8;
	localparam logic [`RV_UPC_WIDTH-1:0] upc_load   = 7'd16;
	localparam logic [`RV_UPC_WIDTH-1:0] upc_system = 7'd24;
	localparam logic [`RV_UPC_WIDTH-1:0] upc_alu    = 7'd32;
	localparam logic [`RV_UPC_WIDTH-1:0] upc_jalr   = 7'd40;
	localparam logic [`RV_UPC_WIDTH-1:0] upc_branch = 7'd48;
	// Both finish in decode and go straight to the next fetch
	localparam logic [`RV_UPC_WIDTH-1:0] upc_upper  = upc_fetch;
	localparam logic [`RV_UPC_WIDTH-1:0] upc_jal    = upc_fetch;

endpackage

/* apb_if.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

interface apb_if;
	logic [`RV_ADDR_WIDTH-1:0]   paddr;
	logic [`RV_DATA_WIDTH-1:0]   pwdata;
	logic [`RV_DATA_WIDTH-1:0]   prdata;
	logic [`RV_DATA_WIDTH/8-1:0] pstrb;   // All ones on reads
	logic                        psel;
	logic                        penable;
	logic                        pwrite;
	logic                        pready;

	modport master (
		output paddr, pwdata, pstrb, psel, penable, pwrite,
		input  prdata, pready
	);

	modport slave (
		input  paddr, pwdata, pstrb, psel, penable, pwrite,
		output prdata, pready
	);
endinterface

/* rv_alu.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_alu (
	input  rv_pkg::alu_op_e          op,
	input  logic [`RV_DATA_WIDTH-1:0] a,
	input  logic [`RV_DATA_WIDTH-1:0] b,
	output logic [`RV_DATA_WIDTH-1:0] y,
	output logic                      cmp
);
	import rv_pkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			alu_add:  y = a + b;
			alu_sub:  y = a - b;
			alu_sll:  y = a << shamt;
			alu_slt:  y = {{(`RV_DATA_WIDTH-1){1'b0}}, $signed(a) < $signed(b)};
			alu_sltu: y = {{(`RV_DATA_WIDTH-1){1'b0}}, a < b};
			alu_xor:  y = a ^ b;
			alu_srl:  y = a >> shamt;
			alu_sra:  y = $signed(a) >>> shamt;
			alu_or:   y = a | b;
			alu_and:  y = a & b;
			default:  y = a + b;
		endcase
	end

	// Branch condition from the funct3 in the low bits of op
	always_comb begin
		case (op[2:0])
			3'b000:  cmp = (a == b);                    // BEQ
			3'b001:  cmp = (a != b);                    // BNE
			3'b100:  cmp = ($signed(a) < $signed(b));   // BLT
			3'b101:  cmp = ($signed(a) >= $signed(b));  // BGE
			3'b110:  cmp = (a < b);                     // BLTU
			3'b111:  cmp = (a >= b);                    // BGEU
			default: cmp = 1'b0;
		endcase
	end
endmodule

/* rv_regfile.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_regfile (
	input  logic                      clk,
	input  logic [4:0]                ra0,
	input  logic [4:0]                ra1,
	output logic [`RV_DATA_WIDTH-1:0] rd0,
	output logic [`RV_DATA_WIDTH-1:0] rd1,
	input  logic                      we,
	input  logic [4:0]                wa,
	input  logic [`RV_DATA_WIDTH-1:0] wd
);
	logic [`RV_DATA_WIDTH-1:0] regs [32];

	// x0 is hardwired to zero
	assign rd0 = (ra0 == 5'd0) ? '0 : regs[ra0];
	assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];

	always_ff @(posedge clk) begin
		if (we && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end
endmodule

/* rv_microcode_rom.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_microcode_rom (
	input  logic [`RV_UPC_WIDTH-1:0] upc,
	output rv_pkg::microop_t         uop
);
	import rv_pkg::*;

	// Setup must sit at zero so the all-zero fetch word continues there
	localparam logic [`RV_UPC_WIDTH-1:0] upc_setup        = 7'd0;
	localparam logic [`RV_UPC_WIDTH-1:0] upc_access       = 7'd1;
	localparam logic [`RV_UPC_WIDTH-1:0] upc_dispatch     = 7'd2;
	localparam logic [`RV_UPC_WIDTH-1:0] upc_store_access = upc_store + 7'd1;
	localparam logic [`RV_UPC_WIDTH-1:0] upc_load_access  = upc_load + 7'd1;

	always_comb begin
		case (upc)
			upc_fetch:    uop = '0;   // Idle step before the instruction read
			upc_setup:    uop = '{next_upc: upc_access, psel: 1'b1, default: '0};
			upc_access:   uop = '{next_upc: upc_dispatch, psel: 1'b1, penable: 1'b1,
			                      default: '0};
			upc_dispatch: uop = '{next_upc: upc_fetch, load_insr: 1'b1, default: '0};
			upc_store: begin
				uop = '{next_upc: upc_store_access, psel: 1'b1, pwrite: 1'b1,
				        mem_access: 1'b1, default: '0};
			end
			upc_store_access: begin
				uop = '{next_upc: upc_fetch, psel: 1'b1, penable: 1'b1, pwrite: 1'b1,
				        mem_access: 1'b1, default: '0};
			end
			upc_load: begin
				uop = '{next_upc: upc_load_access, psel: 1'b1, mem_access: 1'b1,
				        default: '0};
			end
			upc_load_access: begin
				uop = '{next_upc: upc_fetch, psel: 1'b1, penable: 1'b1,
				        mem_access: 1'b1, default: '0};
			end
			upc_alu:      uop = '{next_upc: upc_fetch, store_alu: 1'b1, default: '0};
			upc_jalr:     uop = '{next_upc: upc_fetch, load_pc: 1'b1, default: '0};
			upc_branch:   uop = '{next_upc: upc_fetch, branch: 1'b1, default: '0};
			upc_system:   uop = '{next_upc: upc_fetch, halt: 1'b1, default: '0};
			default:      uop = '{next_upc: upc_fetch, halt: 1'b1, default: '0};
		endcase
	end
endmodule

/* rv_core.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_core (
	input  logic  clk,
	input  logic  reset,
	apb_if.master bus,
	output logic  halted
);
	import rv_pkg::*;

	localparam int xlen = `RV_DATA_WIDTH;

	microop_t                  uop;       // Current micro-op
	microop_t                  rom_uop;
	logic [`RV_UPC_WIDTH-1:0]  upc;
	logic [`RV_UPC_WIDTH-1:0]  entry_upc;
	logic [`RV_ADDR_WIDTH-1:0] pc;
	logic [`RV_ADDR_WIDTH-1:0] maddr;     // Load and store address
	logic [xlen-1:0]           ir;
	logic [xlen-1:0]           wdata;
	logic [3:0]                strb;      // Size mask at the byte lane
	logic [3:0]                size_mask;
	op_group_e                 group;
	alu_op_e                   alu_op;
	logic [xlen-1:0]           rd0, rd1, alu_b, alu_y;
	logic                      alu_cmp;
	logic [xlen-1:0]           rshift, load_data;
	logic                      rf_we;
	logic [xlen-1:0]           rf_wd;

	wire [2:0]      funct3   = ir[14:12];
	wire [xlen-1:0] imm_i    = {{20{ir[31]}}, ir[31:20]};
	wire [xlen-1:0] imm_s    = {{20{ir[31]}}, ir[31:25], ir[11:7]};
	wire [xlen-1:0] imm_b    = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
	wire [xlen-1:0] imm_u    = {ir[31:12], 12'b0};
	wire [xlen-1:0] imm_j    = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
	wire [xlen-1:0] pc_plus4 = pc + 32'd4;
	wire [xlen-1:0] mem_addr = rd0 + ((group == grp_store) ? imm_s : imm_i);
	wire            ex_alu   = (funct3 == 3'b101 || ir[5]) ? ir[30] : 1'b0;   // SUB and SRA

	// Hold everything while the slave inserts wait states
	wire xfer_done = uop.psel & uop.penable & bus.pready;
	wire advance   = ~(uop.psel & uop.penable & ~bus.pready) & ~uop.halt;

	assign bus.psel    = uop.psel;
	assign bus.penable = uop.penable;
	assign bus.pwrite  = uop.pwrite;
	assign bus.paddr   = uop.mem_access ? maddr : pc;
	assign bus.pwdata  = wdata;
	assign bus.pstrb   = uop.pwrite ? strb : 4'b1111;
	assign halted      = uop.halt;

	always_comb begin
		casez (ir[6:0])
			7'b0100011: group = grp_store;
			7'b0000011: group = grp_load;
			7'b0?10111: group = grp_upper;
			7'b0?10011: group = grp_alu;
			7'b1101111: group = grp_jal;
			7'b1100111: group = grp_jalr;
			7'b1100011: group = grp_branch;
			default:    group = grp_system;   // ECALL, zero word, unknown
		endcase
		case (group)
			grp_store:  entry_upc = upc_store;
			grp_load:   entry_upc = upc_load;
			grp_alu:    entry_upc = upc_alu;
			grp_jalr:   entry_upc = upc_jalr;
			grp_branch: entry_upc = upc_branch;
			grp_upper:  entry_upc = upc_upper;
			grp_jal:    entry_upc = upc_jal;
			default:    entry_upc = upc_system;
		endcase
	end

	assign upc    = uop.load_insr ? entry_upc : uop.next_upc;
	assign alu_b  = (ir[5] && group != grp_jalr) ? rd1 : imm_i;
	assign alu_op = (group == grp_alu)    ? alu_op_e'({ex_alu, funct3}) :
	                (group == grp_branch) ? alu_op_e'({1'b0, funct3}) : alu_add;

	always_comb begin
		rshift = bus.prdata >> {maddr[1:0], 3'b000};
		case (funct3)
			3'b000:  load_data = {{24{rshift[7]}}, rshift[7:0]};
			3'b001:  load_data = {{16{rshift[15]}}, rshift[15:0]};
			3'b100:  load_data = {24'b0, rshift[7:0]};
			3'b101:  load_data = {16'b0, rshift[15:0]};
			default: load_data = rshift;
		endcase
		case (funct3[1:0])
			2'b00:   size_mask = 4'b0001;
			2'b01:   size_mask = 4'b0011;
			default: size_mask = 4'b1111;
		endcase
	end

	always_comb begin
		rf_we = 1'b0;
		rf_wd = alu_y;
		if (advance) begin
			if (uop.load_insr && group == grp_upper) begin
				rf_we = 1'b1;
				rf_wd = imm_u + (ir[5] ? '0 : pc);   // LUI or AUIPC
			end else if (uop.load_insr && group == grp_jal) begin
				rf_we = 1'b1;
				rf_wd = pc_plus4;
			end else if (uop.store_alu) begin
				rf_we = 1'b1;
			end else if (uop.load_pc) begin
				rf_we = 1'b1;
				rf_wd = pc_plus4;
			end else if (uop.mem_access && !uop.pwrite && xfer_done) begin
				rf_we = 1'b1;
				rf_wd = load_data;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc  <= '0;
			uop <= '0;   // Same word as the fetch entry
		end else if (advance) begin
			uop <= rom_uop;
			if (uop.load_insr) begin
				case (group)
					grp_jal:                                 pc <= pc + imm_j;
					grp_alu, grp_load, grp_store, grp_upper: pc <= pc_plus4;
					default:                                 pc <= pc;
				endcase
			end
			if (uop.branch) begin
				pc <= alu_cmp ? pc + imm_b : pc_plus4;
			end
			if (uop.load_pc) begin
				pc <= {alu_y[`RV_ADDR_WIDTH-1:1], 1'b0};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			if (xfer_done && !uop.mem_access) begin
				ir <= bus.prdata;   // Instruction read completes
			end
			if (uop.load_insr) begin
				maddr <= mem_addr;
				strb  <= size_mask << mem_addr[1:0];
				wdata <= rd1 << {mem_addr[1:0], 3'b000};
			end
		end
	end

	rv_microcode_rom rom_i (
		.upc (upc),
		.uop (rom_uop)
	);

	rv_regfile regs_i (
		.clk (clk),
		.ra0 (ir[19:15]),
		.ra1 (ir[24:20]),
		.rd0 (rd0),
		.rd1 (rd1),
		.we  (rf_we),
		.wa  (ir[11:7]),
		.wd  (rf_wd)
	);

	rv_alu alu_i (
		.op  (alu_op),
		.a   (rd0),
		.b   (alu_b),
		.y   (alu_y),
		.cmp (alu_cmp)
	);
endmodule

/* apb_ram.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module apb_ram (
	input  logic                              clk,
	input  logic                              reset,
	apb_if.slave                              bus,
	input  logic                              load_en,
	input  logic [$clog2(`RV_MEM_WORDS)-1:0] load_addr,
	input  logic [`RV_DATA_WIDTH-1:0]        load_data,
	input  logic [$clog2(`RV_MEM_WORDS)-1:0] peek_addr,
	output logic [`RV_DATA_WIDTH-1:0]        peek_data
);
	localparam int word_bits = $clog2(`RV_MEM_WORDS);

	logic [`RV_DATA_WIDTH-1:0] mem [`RV_MEM_WORDS];
	logic                      wait_q;   // One wait state per transfer

	wire [word_bits-1:0] word_addr = bus.paddr[word_bits+1:2];

	assign bus.pready = wait_q;
	assign bus.prdata = mem[word_addr];
	assign peek_data  = mem[peek_addr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wait_q <= 1'b0;
		end else begin
			wait_q <= bus.psel & bus.penable & ~wait_q;
		end
	end

	// Program load only while the core is held in reset
	always_ff @(posedge clk) begin
		if (reset && load_en) begin
			mem[load_addr] <= load_data;
		end else if (bus.psel && bus.penable && bus.pready && bus.pwrite) begin
			for (int i = 0; i < `RV_DATA_WIDTH/8; i++) begin
				if (bus.pstrb[i]) begin
					mem[word_addr][8*i +: 8] <= bus.pwdata[8*i +: 8];
				end
			end
		end
	end
endmodule

/* rv_system.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_system (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              load_en,
	input  logic [$clog2(`RV_MEM_WORDS)-1:0] load_addr,   // Word index
	input  logic [`RV_DATA_WIDTH-1:0]        load_data,
	input  logic [$clog2(`RV_MEM_WORDS)-1:0] peek_addr,
	output logic [`RV_DATA_WIDTH-1:0]        peek_data,
	output logic                              halted
);
	apb_if bus_i ();

	rv_core core_i (
		.clk    (clk),
		.reset  (reset),
		.bus    (bus_i.master),
		.halted (halted)
	);

	apb_ram ram_i (
		.clk       (clk),
		.reset     (reset),
		.bus       (bus_i.slave),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.peek_addr (peek_addr),
		.peek_data (peek_data)
	);
endmodule

/* tb_rv_system.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module tb_rv_system;
	localparam int addr_bits     = $clog2(`RV_MEM_WORDS);
	localparam int half_period   = 50;
	localparam int drive_delay   = 5;    // Inputs change this long after the rising edge
	localparam int settle_cycles = 16;   // Extra cycles after halt to catch a late store
	localparam int cycles_per_word = 200;

	logic                      clk;
	logic                      reset;
	logic                      load_en;
	logic [addr_bits-1:0]      load_addr;
	logic [`RV_DATA_WIDTH-1:0] load_data;
	logic [addr_bits-1:0]      peek_addr;
	logic [`RV_DATA_WIDTH-1:0] peek_data;
	logic                      halted;

	// Records of rv_cases.txt in file order
	logic [7:0]                rec_kind [$];   // p, e or r
	logic [addr_bits-1:0]      rec_addr [$];
	logic [`RV_DATA_WIDTH-1:0] rec_data [$];
	logic [8*32-1:0]           case_name [$];

	int n_prog_words = 0;
	int n_exp_words  = 0;
	int pass_count   = 0;
	int fail_count   = 0;
	int case_errors  = 0;
	bit cases_read   = 1'b0;

	rv_system dut_i (
		.clk       (clk),
		.reset     (reset),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.peek_addr (peek_addr),
		.peek_data (peek_data),
		.halted    (halted)
	);

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	task automatic next_cycle();
		@(posedge clk);
		#drive_delay;
	endtask

	task automatic read_cases();
		int               fd;
		int               code;
		logic [8*128-1:0] line;
		logic [8*8-1:0]   tag;
		logic [8*32-1:0]  name;
		logic [31:0]      addr;
		logic [31:0]      data;
		fd = $fopen("rv_cases.txt", "r");
		if (fd == 0) begin
			$display("Cannot open rv_cases.txt");
		end else begin
			while (!$feof(fd)) begin
				line = '0;
				tag  = '0;
				code = $fgets(line, fd);
				if (code > 0) begin
					code = $sscanf(line, "%s", tag);
				end
				if (code > 0 && (tag == "p" || tag == "e")) begin
					code = $sscanf(line, "%s %h %h", tag, addr, data);
					if (code == 3) begin
						rec_kind.push_back(tag[7:0]);
						rec_addr.push_back(addr[addr_bits-1:0]);
						rec_data.push_back(data);
						if (tag == "p") n_prog_words++;
						else n_exp_words++;
					end
				end else if (code > 0 && tag == "run") begin
					name = '0;
					code = $sscanf(line, "%s %s", tag, name);
					rec_kind.push_back("r");
					rec_addr.push_back('0);
					rec_data.push_back('0);
					case_name.push_back(name);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic compare_word(input logic [addr_bits-1:0] addr,
			input logic [`RV_DATA_WIDTH-1:0] expected,
			input logic [`RV_DATA_WIDTH-1:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: word 0x%03h expected 0x%08h, actual 0x%08h",
				$time, addr, expected, actual);
			case_errors++;
		end
	endtask

	task automatic compare_flag(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %0s expected %b, actual %b",
				$time, what, expected, actual);
			case_errors++;
		end
	endtask

	task automatic load_word(input logic [addr_bits-1:0] addr,
			input logic [`RV_DATA_WIDTH-1:0] data);
		load_en   = 1'b1;
		load_addr = addr;
		load_data = data;
		next_cycle();
	endtask

	task automatic clear_memory();
		for (int w = 0; w < `RV_MEM_WORDS; w++) begin
			load_word(addr_bits'(w), '0);
		end
	endtask

	// Records first..last-1 belong to this case
	task automatic run_case(input logic [8*32-1:0] name, input int first, input int last);
		int checks;
		checks      = 0;
		case_errors = 0;
		reset       = 1'b1;
		repeat (2) next_cycle();
		clear_memory();
		for (int i = first; i < last; i++) begin
			if (rec_kind[i] == "p") begin
				load_word(rec_addr[i], rec_data[i]);
			end
		end
		load_en = 1'b0;
		reset   = 1'b0;
		compare_flag("halted after reset", 1'b0, halted);
		while (halted !== 1'b1) begin
			next_cycle();   // Watchdog bounds this loop
		end
		repeat (settle_cycles) next_cycle();
		compare_flag("halted held", 1'b1, halted);
		for (int i = first; i < last; i++) begin
			if (rec_kind[i] == "e") begin
				peek_addr = rec_addr[i];
				next_cycle();
				compare_word(rec_addr[i], rec_data[i], peek_data);
				checks++;
			end
		end
		if (case_errors == 0) begin
			pass_count++;
			$display("Case %0s passed, %0d words checked", name, checks);
		end else begin
			fail_count++;
			$display("Case %0s failed with %0d errors", name, case_errors);
		end
	endtask

	initial begin
		int limit;
		wait (cases_read);
		// Memory clear and run time of every case
		limit = case_name.size() * (`RV_MEM_WORDS + 32) + cycles_per_word * n_prog_words
			+ n_exp_words;
		repeat (limit) @(posedge clk);
		$display("Timeout after %0d cycles: the core never halted", limit);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		int first;
		int case_idx;
		reset     = 1'b1;
		load_en   = 1'b0;
		load_addr = '0;
		load_data = '0;
		peek_addr = '0;
		read_cases();
		cases_read = 1'b1;
		next_cycle();
		first    = 0;
		case_idx = 0;
		for (int i = 0; i < rec_kind.size(); i++) begin
			if (rec_kind[i] == "r") begin
				run_case(case_name[case_idx], first, i);
				case_idx++;
				first = i + 1;
			end
		end
		if (case_idx == 0) begin
			$display("No test cases were read from rv_cases.txt");
		end
		$display("Cases passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && pass_count > 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end
endmodule

/* project.f */
+incdir+.
rv_pkg.sv
apb_if.sv
rv_alu.sv
rv_regfile.sv
rv_microcode_rom.sv
rv_core.sv
apb_ram.sv
rv_system.sv
tb_rv_system.sv

/* rv_cases.txt */
# Columns: kind, word address (hex), word (hex); p loads a word, e expects it after the run
# "run <name>" resets, loads the p words since the last run line and checks the e words
p 000 06400093  # addi x1, x0, 100
p 001 ff900113  # addi x2, x0, -7
p 002 402081b3  # sub  x3, x1, x2
p 003 40115213  # srai x4, x2, 1
p 004 0020b2b3  # sltu x5, x1, x2
p 005 00112333  # slt  x6, x2, x1
p 006 0f00c393  # xori x7, x1, 0xf0
p 007 00309413  # slli x8, x1, 3
p 008 001154b3  # srl  x9, x2, x1
p 009 40115533  # sra  x10, x2, x1
p 00a 0020f5b3  # and  x11, x1, x2
p 00b 0020e633  # or   x12, x1, x2
p 00c 002086b3  # add  x13, x1, x2
p 00d 10302023
p 00e 10402223
p 00f 10502423
p 010 10602623
p 011 10702823
p 012 10802a23
p 013 10902c23
p 014 10a02e23
p 015 12b02023
p 016 12c02223
p 017 12d02423
p 018 00000073  # ecall
e 040 0000006b
e 041 fffffffc
e 042 00000001
e 043 00000001
e 044 00000094
e 045 00000320
e 046 0fffffff
e 047 ffffffff
e 048 00000060
e 049 fffffffd
e 04a 0000005d
run alu_ops
p 000 14000083  # lb  x1, 0x140(x0)
p 001 14004103  # lbu x2, 0x140(x0)
p 002 14100183  # lb  x3, 0x141(x0)
p 003 14201203  # lh  x4, 0x142(x0)
p 004 14205283  # lhu x5, 0x142(x0)
p 005 14001303  # lh  x6, 0x140(x0)
p 006 10102023
p 007 10202223
p 008 10302423
p 009 10402623
p 00a 10502823
p 00b 10602a23
p 00c fab00393  # addi x7, x0, -85
p 00d 147002a3  # sb x7, 0x145(x0)
p 00e 14701523  # sh x7, 0x14a(x0)
p 00f 00000073
p 050 80f17f85
p 051 11223344
p 052 55667788
e 040 ffffff85
e 041 00000085
e 042 0000007f
e 043 ffff80f1
e 044 000080f1
e 045 00007f85
e 050 80f17f85
e 051 1122ab44
e 052 ffab7788
run load_store_sizes
p 000 00500093  # addi x1, x0, 5
p 001 ffd00113  # addi x2, x0, -3
p 002 05a00193  # addi x3, x0, 0x5a
p 003 00208463  # beq  x1, x2, +8 not taken
p 004 10302023
p 005 00209463  # bne  x1, x2, +8 taken
p 006 10302223
p 007 00114463  # blt  x2, x1, +8 taken
p 008 10302423
p 009 00116463  # bltu x2, x1, +8 not taken
p 00a 10302623
p 00b 00115463  # bge  x2, x1, +8 not taken
p 00c 10302823
p 00d 00117463  # bgeu x2, x1, +8 taken
p 00e 10302a23
p 00f 00300213  # addi x4, x0, 3
p 010 00000293  # addi x5, x0, 0
p 011 00128293  # addi x5, x5, 1
p 012 fff20213  # addi x4, x4, -1
p 013 fe021ce3  # bne  x4, x0, -8
p 014 10502c23
p 015 00000073
e 040 0000005a
e 041 00000000
e 042 00000000
e 043 0000005a
e 044 0000005a
e 045 00000000
e 046 00000003
run branches
p 000 123450b7  # lui   x1, 0x12345
p 001 00001117  # auipc x2, 1
p 002 00c001ef  # jal   x3, +12
p 003 10102e23
p 004 10102e23
p 005 01d00213  # addi x4, x0, 29
p 006 004202e7  # jalr x5, 4(x4)
p 007 10102e23
p 008 10102023
p 009 10202223
p 00a 10302423
p 00b 10502623
p 00c 00000073
e 040 12345000
e 041 00001004
e 042 0000000c
e 043 0000001c
e 047 00000000
run jumps_upper
p 000 12300013  # addi x0, x0, 0x123
p 001 abcde037  # lui  x0, 0xabcde
p 002 10002023  # sw   x0, 0x100(x0)
p 003 00700093  # addi x1, x0, 7
p 004 10102223
p 005 0080006f  # jal  x0, +8
p 006 10102423
p 007 10002623  # sw   x0, 0x10c(x0)
p 008 00000073
p 040 deadbeef
p 043 cafef00d
e 040 00000000
e 041 00000007
e 042 00000000
e 043 00000000
run x0_writes
p 000 03300093  # addi x1, x0, 0x33
p 001 10102023
p 002 00000000
p 003 10102223
e 040 00000033
e 041 00000000
run halt_zero
p 000 03300093
p 001 10102023
p 002 00000073
p 003 10102223
e 040 00000033
e 041 00000000
run halt_ecall
p 000 03300093
p 001 10102023
p 002 0020a00b  # custom-0 opcode
p 003 10102223
e 040 00000033
e 041 00000000
run halt_unknown
